// File: csr_file.f
+incdir+design
design/csr_pkg.sv
design/csr_exc_regs.sv
design/csr_int_ctrl.sv
design/csr_timer.sv
design/csr_save_regs.sv
design/csr_file.sv
verification/csr_file_tb.sv

// File: design/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Register numbers
`define CSR_CRMD    14'h0000
`define CSR_PRMD    14'h0001
`define CSR_ECFG    14'h0004
`define CSR_ESTAT   14'h0005
`define CSR_ERA     14'h0006
`define CSR_BADV    14'h0007
`define CSR_EENTRY  14'h000c
`define CSR_SAVE0   14'h0030
`define CSR_SAVE1   14'h0031
`define CSR_SAVE2   14'h0032
`define CSR_SAVE3   14'h0033
`define CSR_TID     14'h0040
`define CSR_TCFG    14'h0041
`define CSR_TVAL    14'h0042
`define CSR_TICLR   14'h0044

// Field ranges
`define CSR_CRMD_PLV        1:0
`define CSR_CRMD_IE         2
`define CSR_CRMD_DA         3
`define CSR_CRMD_PG         4
`define CSR_PRMD_PPLV       1:0
`define CSR_PRMD_PIE        2
`define CSR_ECFG_LIE        12:0
`define CSR_ESTAT_IS10      1:0
`define CSR_EENTRY_VA       31:6
`define CSR_TCFG_EN         0
`define CSR_TCFG_PERIODIC   1
`define CSR_TCFG_INITVAL    31:2
`define CSR_TICLR_CLR       0

// Exception codes
`define ECODE_ADE      6'h08
`define ECODE_ALE      6'h09
`define ESUBCODE_ADEF  9'h000

`define TIMER_IDLE  32'hffff_ffff

`endif

// File: design/csr_exc_regs.sv
`include "csr_defs.svh"

module csr_exc_regs
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  csr_wr_t   csr_wr,
  input  exc_req_t  exc,
  input  logic      eret_flush,
  input  csr_num_t  csr_num,
  input  int_vec_t  int_status,
  output logic      crmd_ie,
  output csr_word_t rdata
);

  plv_t        crmd_plv;
  logic        crmd_da;
  logic        crmd_pg;
  plv_t        prmd_pplv;
  logic        prmd_pie;
  ecode_t      estat_ecode;
  esubcode_t   estat_esubcode;
  csr_word_t   era;
  csr_word_t   badv;
  logic [25:0] eentry_va;

  csr_word_t crmd_rvalue;
  csr_word_t prmd_rvalue;
  csr_word_t estat_rvalue;
  csr_word_t eentry_rvalue;
  csr_word_t crmd_next;
  csr_word_t prmd_next;
  csr_word_t eentry_next;
  logic      addr_err;

  assign crmd_rvalue   = {27'b0, crmd_pg, crmd_da, crmd_ie, crmd_plv};
  assign prmd_rvalue   = {29'b0, prmd_pie, prmd_pplv};
  assign estat_rvalue  = {1'b0, estat_esubcode, estat_ecode, 3'b0, int_status};
  assign eentry_rvalue = {eentry_va, 6'b0};

  assign crmd_next   = masked_merge(crmd_rvalue, csr_wr);
  assign prmd_next   = masked_merge(prmd_rvalue, csr_wr);
  assign eentry_next = masked_merge(eentry_rvalue, csr_wr);

  assign addr_err = (exc.ecode == `ECODE_ADE) || (exc.ecode == `ECODE_ALE);

  // Exception beats ERET, ERET beats a CSR write
  always_ff @(posedge clk) begin
    if (reset) begin
      crmd_plv <= '0;
      crmd_ie  <= 1'b0;
      crmd_da  <= 1'b1;
      crmd_pg  <= 1'b0;
    end else if (exc.ex) begin
      crmd_plv <= '0;
      crmd_ie  <= 1'b0;
    end else if (eret_flush) begin
      crmd_plv <= prmd_pplv;
      crmd_ie  <= prmd_pie;
    end else if (csr_wr.we && csr_wr.num == `CSR_CRMD) begin
      crmd_plv <= crmd_next[`CSR_CRMD_PLV];
      crmd_ie  <= crmd_next[`CSR_CRMD_IE];
      crmd_da  <= crmd_next[`CSR_CRMD_DA];
      crmd_pg  <= crmd_next[`CSR_CRMD_PG];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prmd_pplv      <= '0;
      prmd_pie       <= 1'b0;
      estat_ecode    <= '0;
      estat_esubcode <= '0;
      era            <= '0;
      badv           <= '0;
      eentry_va      <= '0;
    end else if (exc.ex) begin
      prmd_pplv      <= crmd_plv;
      prmd_pie       <= crmd_ie;
      estat_ecode    <= exc.ecode;
      estat_esubcode <= exc.esubcode;
      era            <= exc.pc;
      if (addr_err) begin
        // Fetch faults report the PC itself
        badv <= (exc.ecode == `ECODE_ADE && exc.esubcode == `ESUBCODE_ADEF) ? exc.pc : exc.vaddr;
      end
    end else if (csr_wr.we && !eret_flush) begin
      case (csr_wr.num)
        `CSR_PRMD: begin
          prmd_pplv <= prmd_next[`CSR_PRMD_PPLV];
          prmd_pie  <= prmd_next[`CSR_PRMD_PIE];
        end
        `CSR_ERA:    era       <= masked_merge(era, csr_wr);
        `CSR_BADV:   badv      <= masked_merge(badv, csr_wr);
        `CSR_EENTRY: eentry_va <= eentry_next[`CSR_EENTRY_VA];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (csr_num)
      `CSR_CRMD:   rdata = crmd_rvalue;
      `CSR_PRMD:   rdata = prmd_rvalue;
      `CSR_ESTAT:  rdata = estat_rvalue;
      `CSR_ERA:    rdata = era;
      `CSR_BADV:   rdata = badv;
      `CSR_EENTRY: rdata = eentry_rvalue;
      default:     rdata = '0;
    endcase
  end

  // Writeback never reports an exception and an ERET together
  a_exc_eret_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(exc.ex && eret_flush));

endmodule

// File: design/csr_file.sv
module csr_file
  import csr_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  csr_num_t   csr_num,
  output csr_word_t  csr_rvalue,
  input  csr_wr_t    csr_wr,
  input  exc_req_t   exc,
  input  logic       eret_flush,
  input  logic       ipi_int_in,
  input  logic [7:0] hw_int_in,
  input  csr_word_t  coreid_in,
  output logic       has_int
);

  logic      crmd_ie;
  logic      ti_pending;
  int_vec_t  int_status;
  csr_word_t exc_rdata;
  csr_word_t int_rdata;
  csr_word_t timer_rdata;
  csr_word_t save_rdata;

  csr_exc_regs u_exc_regs (
    .clk        (clk),
    .reset      (reset),
    .csr_wr     (csr_wr),
    .exc        (exc),
    .eret_flush (eret_flush),
    .csr_num    (csr_num),
    .int_status (int_status),
    .crmd_ie    (crmd_ie),
    .rdata      (exc_rdata)
  );

  csr_int_ctrl u_int_ctrl (
    .clk        (clk),
    .reset      (reset),
    .csr_wr     (csr_wr),
    .csr_num    (csr_num),
    .hw_int_in  (hw_int_in),
    .ipi_int_in (ipi_int_in),
    .ti_pending (ti_pending),
    .crmd_ie    (crmd_ie),
    .int_status (int_status),
    .has_int    (has_int),
    .rdata      (int_rdata)
  );

  csr_timer u_timer (
    .clk        (clk),
    .reset      (reset),
    .csr_wr     (csr_wr),
    .csr_num    (csr_num),
    .coreid_in  (coreid_in),
    .ti_pending (ti_pending),
    .rdata      (timer_rdata)
  );

  csr_save_regs u_save_regs (
    .clk     (clk),
    .reset   (reset),
    .csr_wr  (csr_wr),
    .csr_num (csr_num),
    .rdata   (save_rdata)
  );

  // Each block returns zero for numbers it does not own
  assign csr_rvalue = exc_rdata | int_rdata | timer_rdata | save_rdata;

endmodule

// File: design/csr_int_ctrl.sv
`include "csr_defs.svh"

module csr_int_ctrl
  import csr_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  csr_wr_t    csr_wr,
  input  csr_num_t   csr_num,
  input  logic [7:0] hw_int_in,
  input  logic       ipi_int_in,
  input  logic       ti_pending,
  input  logic       crmd_ie,
  output int_vec_t   int_status,
  output logic       has_int,
  output csr_word_t  rdata
);

  int_vec_t   ecfg_lie;
  logic [1:0] is_sw;
  logic [7:0] is_hw;
  logic       is_ipi;
  csr_word_t  ecfg_next;
  csr_word_t  estat_next;

  assign ecfg_next  = masked_merge({19'b0, ecfg_lie}, csr_wr);
  assign estat_next = masked_merge({19'b0, int_status}, csr_wr);

  always_ff @(posedge clk) begin
    if (reset) begin
      ecfg_lie <= '0;
      is_sw    <= '0;
    end else if (csr_wr.we && csr_wr.num == `CSR_ECFG) begin
      ecfg_lie <= ecfg_next[`CSR_ECFG_LIE];
    end else if (csr_wr.we && csr_wr.num == `CSR_ESTAT) begin
      // Only the two software bits are writable
      is_sw <= estat_next[`CSR_ESTAT_IS10];
    end
  end

  // External lines are sampled every cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      is_hw  <= '0;
      is_ipi <= 1'b0;
    end else begin
      is_hw  <= hw_int_in;
      is_ipi <= ipi_int_in;
    end
  end

  assign int_status = {is_ipi, ti_pending, 1'b0, is_hw, is_sw};

  // IPI at bit 12 is outside the request window
  assign has_int = (|(int_status[11:0] & ecfg_lie[11:0])) && crmd_ie;

  assign rdata = (csr_num == `CSR_ECFG) ? {19'b0, ecfg_lie} : '0;

endmodule

// File: design/csr_pkg.sv
package csr_pkg;

  typedef logic [13:0] csr_num_t;
  typedef logic [31:0] csr_word_t;
  typedef logic [1:0]  plv_t;
  typedef logic [5:0]  ecode_t;
  typedef logic [8:0]  esubcode_t;
  typedef logic [12:0] int_vec_t;

  // CSR write bus, broadcast to every register block
  typedef struct packed {
    logic      we;
    csr_num_t  num;
    csr_word_t wmask;
    csr_word_t wvalue;
  } csr_wr_t;

  // Exception report from writeback
  typedef struct packed {
    logic      ex;
    ecode_t    ecode;
    esubcode_t esubcode;
    csr_word_t pc;
    csr_word_t vaddr;
  } exc_req_t;

  // Bits under the mask take the new value, the rest keep the old one
  function automatic csr_word_t masked_merge(input csr_word_t old_value, input csr_wr_t wr);
    return (wr.wmask & wr.wvalue) | (~wr.wmask & old_value);
  endfunction

endpackage

// File: design/csr_save_regs.sv
`include "csr_defs.svh"

module csr_save_regs
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  csr_wr_t   csr_wr,
  input  csr_num_t  csr_num,
  output csr_word_t rdata
);

  csr_word_t  save_q [4];
  logic       wr_hit;
  logic       rd_hit;
  logic [1:0] wr_idx;
  logic [1:0] rd_idx;

  // SAVE0 to SAVE3 are consecutive numbers
  assign wr_hit = csr_wr.we && csr_wr.num >= `CSR_SAVE0 && csr_wr.num <= `CSR_SAVE3;
  assign rd_hit = csr_num >= `CSR_SAVE0 && csr_num <= `CSR_SAVE3;
  assign wr_idx = 2'(csr_wr.num - `CSR_SAVE0);
  assign rd_idx = 2'(csr_num - `CSR_SAVE0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 4; i++) begin
        save_q[i] <= '0;
      end
    end else if (wr_hit) begin
      save_q[wr_idx] <= masked_merge(save_q[wr_idx], csr_wr);
    end
  end

  assign rdata = rd_hit ? save_q[rd_idx] : '0;

endmodule

// File: design/csr_timer.sv
`include "csr_defs.svh"

module csr_timer
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  csr_wr_t   csr_wr,
  input  csr_num_t  csr_num,
  input  csr_word_t coreid_in,
  output logic      ti_pending,
  output csr_word_t rdata
);

  csr_word_t   tid;
  logic        tcfg_en;
  logic        tcfg_periodic;
  logic [29:0] tcfg_initval;
  csr_word_t   timer_cnt;

  csr_word_t tcfg_rvalue;
  csr_word_t tcfg_next;
  logic      wr_tcfg;
  logic      timer_load;
  logic      ticlr_hit;

  assign tcfg_rvalue = {tcfg_initval, tcfg_periodic, tcfg_en};
  assign tcfg_next   = masked_merge(tcfg_rvalue, csr_wr);
  assign wr_tcfg     = csr_wr.we && csr_wr.num == `CSR_TCFG;
  assign timer_load  = wr_tcfg && tcfg_next[`CSR_TCFG_EN];
  assign ticlr_hit   = csr_wr.we && csr_wr.num == `CSR_TICLR &&
                       csr_wr.wmask[`CSR_TICLR_CLR] && csr_wr.wvalue[`CSR_TICLR_CLR];

  always_ff @(posedge clk) begin
    if (reset) begin
      tid <= coreid_in;
    end else if (csr_wr.we && csr_wr.num == `CSR_TID) begin
      tid <= masked_merge(tid, csr_wr);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tcfg_en       <= 1'b0;
      tcfg_periodic <= 1'b0;
      tcfg_initval  <= '0;
    end else if (wr_tcfg) begin
      tcfg_en       <= tcfg_next[`CSR_TCFG_EN];
      tcfg_periodic <= tcfg_next[`CSR_TCFG_PERIODIC];
      tcfg_initval  <= tcfg_next[`CSR_TCFG_INITVAL];
    end
  end

  // Counter runs in units of one cycle, INITVAL counts in fours
  always_ff @(posedge clk) begin
    if (reset) begin
      timer_cnt <= `TIMER_IDLE;
    end else if (timer_load) begin
      timer_cnt <= {tcfg_next[`CSR_TCFG_INITVAL], 2'b00};
    end else if (tcfg_en && timer_cnt != `TIMER_IDLE) begin
      if (timer_cnt == '0) begin
        timer_cnt <= tcfg_periodic ? {tcfg_initval, 2'b00} : `TIMER_IDLE;
      end else begin
        timer_cnt <= timer_cnt - 32'd1;
      end
    end
  end

  // Expiry wins over a clear in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      ti_pending <= 1'b0;
    end else if (timer_cnt == '0) begin
      ti_pending <= 1'b1;
    end else if (ticlr_hit) begin
      ti_pending <= 1'b0;
    end
  end

  always_comb begin
    case (csr_num)
      `CSR_TID:   rdata = tid;
      `CSR_TCFG:  rdata = tcfg_rvalue;
      `CSR_TVAL:  rdata = timer_cnt;
      default:    rdata = '0;
    endcase
  end

  a_cnt_frozen_when_off: assert property (@(posedge clk) disable iff (reset)
    (!tcfg_en && !timer_load) |=> $stable(timer_cnt));

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module csr_file_tb -f csr_file.f || exit 1
out=$(./obj_dir/Vcsr_file_tb)
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1

// File: verification/csr_file_tb.sv
module csr_file_tb
  import csr_pkg::*;
();

  localparam int NAME_CHARS = 24;

  typedef logic [8*NAME_CHARS-1:0] test_name_t;

  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] a3;
    test_name_t  name;
  } test_cmd_t;

  logic       clk;
  logic       reset;
  csr_num_t   csr_num;
  csr_word_t  csr_rvalue;
  csr_wr_t    csr_wr;
  exc_req_t   exc;
  logic       eret_flush;
  logic       ipi_int_in;
  logic [7:0] hw_int_in;
  csr_word_t  coreid_in;
  logic       has_int;

  test_cmd_t cmds[$];
  int        cycle_count;
  int        cycle_limit;

  csr_file u_csr_file (
    .clk        (clk),
    .reset      (reset),
    .csr_num    (csr_num),
    .csr_rvalue (csr_rvalue),
    .csr_wr     (csr_wr),
    .exc        (exc),
    .eret_flush (eret_flush),
    .ipi_int_in (ipi_int_in),
    .hw_int_in  (hw_int_in),
    .coreid_in  (coreid_in),
    .has_int    (has_int)
  );

  always #2 clk = ~clk;

  // Limit stays off until the test file has been loaded
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout: the run went past %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  task automatic check_word(input test_name_t name, input csr_word_t expected,
                            input csr_word_t actual);
    if (actual !== expected) begin
      $display("mismatch %0s expected %h actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "register check failed");
    end
  endtask

  task automatic check_int(input test_name_t name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch %0s expected %b actual %b", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "interrupt check failed");
    end
  endtask

  task automatic load_tests();
    int               fd;
    int               r;
    int               total;
    logic [7:0]       op;
    logic [31:0]      a0;
    logic [31:0]      a1;
    logic [31:0]      a2;
    logic [31:0]      a3;
    test_name_t       name;
    logic [8*128-1:0] line;
    test_cmd_t        c;
    total = 0;
    fd = $fopen("verification/csr_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test file verification/csr_tests.txt");
      $display("TEST FAILED");
      $fatal(1, "no stimulus available");
    end else begin
      while ($fscanf(fd, "%s", op) == 1) begin
        a0 = '0;
        a1 = '0;
        a2 = '0;
        a3 = '0;
        name = '0;
        case (op)
          "#": r = $fgets(line, fd);
          "K": r = $fscanf(fd, "%h", a0);
          "W": r = $fscanf(fd, "%h %h %h", a0, a1, a2);
          "E": r = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
          "X": r = 0;
          "I": r = $fscanf(fd, "%h %h", a0, a1);
          "C": r = $fscanf(fd, "%d", a0);
          "R": r = $fscanf(fd, "%h %h %s", a0, a1, name);
          "H": r = $fscanf(fd, "%d %s", a0, name);
          default: begin
            $display("unknown command %c in the test file", op);
            $display("TEST FAILED");
            $fatal(1, "bad test file");
          end
        endcase
        if (op == "K") begin
          coreid_in = a0;
        end else if (op != "#") begin
          c = {op, a0, a1, a2, a3, name};
          cmds.push_back(c);
          total += (op == "C") ? int'(a0) : 1;
        end
      end
      $fclose(fd);
      cycle_limit = total + 100;
    end
  endtask

  // Strobes last one cycle, interrupt lines hold until the next I command
  task automatic run_cmd(input test_cmd_t c);
    int n;
    n = (c.op == "C") ? int'(c.a0) : 1;
    repeat (n) begin
      @(posedge clk);
      csr_wr.we  <= 1'b0;
      exc.ex     <= 1'b0;
      eret_flush <= 1'b0;
    end
    case (c.op)
      "W": begin
        csr_wr.we     <= 1'b1;
        csr_wr.num    <= c.a0[13:0];
        csr_wr.wmask  <= c.a1;
        csr_wr.wvalue <= c.a2;
      end
      "E": begin
        exc.ex       <= 1'b1;
        exc.ecode    <= c.a0[5:0];
        exc.esubcode <= c.a1[8:0];
        exc.pc       <= c.a2;
        exc.vaddr    <= c.a3;
      end
      "X": eret_flush <= 1'b1;
      "I": begin
        hw_int_in  <= c.a0[7:0];
        ipi_int_in <= c.a1[0];
      end
      "R": begin
        csr_num <= c.a0[13:0];
        @(negedge clk);
        check_word(c.name, c.a1, csr_rvalue);
      end
      "H": begin
        @(negedge clk);
        check_int(c.name, c.a0[0], has_int);
      end
      default: ;
    endcase
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    csr_num     = '0;
    csr_wr      = '0;
    exc         = '0;
    eret_flush  = 1'b0;
    ipi_int_in  = 1'b0;
    hw_int_in   = '0;
    coreid_in   = '0;
    cycle_count = 0;
    cycle_limit = 0;
    load_tests();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    foreach (cmds[i]) begin
      run_cmd(cmds[i]);
    end
    @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: verification/csr_tests.txt
# op and hex fields; C count and H bit are decimal; R and H end with a test name
# K coreid | W num mask value | E ecode subcode pc vaddr | X | I hw ipi | C n | R num exp name | H bit name
K 00000005
R 40 00000005 tid_reset
R 0 00000008 crmd_reset
W 30 ffffffff 12345678
W 31 0000ffff aaaabbbb
W 32 ff00ff00 cafef00d
W 33 ffffffff 0badc0de
W 33 000000ff 00000011
R 30 12345678 save0_full
R 31 0000bbbb save1_low_half
R 32 ca00f000 save2_bytes
R 33 0badc011 save3_merge
W c ffffffff 1c0001ff
R c 1c0001c0 eentry_align
W 4 ffffffff ffffffff
R 4 00001fff ecfg_width
W 4 ffffffff 00000000
R 10 00000000 dropped_tlbidx
R 180 00000000 dropped_dmw0
W 0 00000007 00000007
R 0 0000000f crmd_plv3_ie
E 08 000 1c000100 00000000
R 0 00000008 adef_crmd
R 1 00000007 adef_prmd
R 6 1c000100 adef_era
R 7 1c000100 adef_badv
R 5 00080000 adef_estat
X
R 0 0000000f eret_crmd
E 09 000 1c000200 00000abc
R 7 00000abc ale_badv
R 5 00090000 ale_estat
X
R 0 0000000f eret_crmd2
W 41 ffffffff 00000015
R 42 00000014 oneshot_load
C 4
R 42 0000000f oneshot_count
C 20
R 42 ffffffff oneshot_idle
R 5 00090800 ti_pending_set
H 0 no_lie
W 4 00000800 00000800
H 1 timer_int
W 0 00000004 00000000
H 0 ie_off
W 0 00000004 00000004
H 1 ie_on
W 44 00000001 00000001
H 0 ticlr_drop
R 5 00090000 ticlr_estat
I 0a 1
R 5 00091028 ext_lines
H 0 hw_masked
W 4 00001fff 00001000
H 0 ipi_no_int
W 4 00001fff 00000008
H 1 hw_int
I 00 0
H 0 hw_released
W 4 00001fff 00000002
W 5 00000003 00000002
H 1 swi_int
R 5 00090002 swi_estat
W 5 00000003 00000000
H 0 swi_clear
W 41 ffffffff 0000000b
R 42 00000008 periodic_load
C 8
R 42 00000008 periodic_reload
C 3
R 42 00000004 periodic_count
